/* src/lsu_pkg.sv */
/*
 * Shared definitions for the load/store address path.
 * Holds the page and cache-line geometry, the width of the index scale
 * field and the enumerations for addressing modes and controller states.
 * Modules pull these in with a wildcard import in their header.
 */

package lsu_pkg;

	// ==================================================
	// Geometry
	// ==================================================

	// Page offset width, which gives 4 KiB pages
	localparam int PAGE_BITS = 12;

	// Cache-line offset width, which gives 64-byte lines
	localparam int LINE_BITS = 6;

	// Scale field width, so the index is shifted left by 0 to 3
	localparam int SCALE_W = 2;

	// Width of a TLB entry index
	// A single-entry TLB still needs one index bit on its write port
	function automatic int idx_width(input int entries);
		return (entries > 1) ? $clog2(entries) : 1;
	endfunction

	// ==================================================
	// Enumerations
	// ==================================================

	// Addressing modes, already decoded by the issuing stage
	// AM_BASE is also the mode used for atomics
	typedef enum logic [1:0] {
		AM_BASE    = 2'd0,
		AM_DISP    = 2'd1,
		AM_INDEXED = 2'd2
	} addr_mode_e;

	// Controller states, one request in flight at a time
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_AGEN  = 3'd1,
		ST_XLATE = 3'd2,
		ST_BUS   = 3'd3,
		ST_DONE  = 3'd4
	} lsu_state_e;

endpackage

/* src/tlb_lookup_if.sv */
/*
 * Translation request and result between the controller and the data TLB.
 * The controller pulses lookup with a virtual address and one cycle later
 * the TLB pulses result_valid with hit and the physical address.
 */

`timescale 1ns/1ps

interface tlb_lookup_if #(
	parameter int ADDR_W = 32
);

	// Request side, driven by the controller
	logic              lookup;
	logic [ADDR_W-1:0] vaddr;

	// Result side, registered inside the TLB
	logic              result_valid;
	logic              hit;
	logic [ADDR_W-1:0] paddr;

	modport ctrl (
		output lookup, vaddr,
		input  result_valid, hit, paddr
	);

	modport tlb (
		input  lookup, vaddr,
		output result_valid, hit, paddr
	);

endinterface

/* src/agen.sv */
/*
 * Effective-address generator.
 * Forms base, base plus displacement, or base plus scaled index plus
 * displacement, optionally rounded up to the start of the next cache line.
 * The address is captured on issue and res_valid stays set until release.
 */

`timescale 1ns/1ps

module agen import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue,
	input  logic               res_release,
	input  addr_mode_e         mode,
	input  logic               next_line,
	input  logic [ADDR_W-1:0]  base,
	input  logic [ADDR_W-1:0]  index,
	input  logic [ADDR_W-1:0]  disp,
	input  logic [SCALE_W-1:0] scale,
	output logic [ADDR_W-1:0]  res,
	output logic               res_valid
);

	// Width of the line number above the line offset
	localparam int LINE_W = ADDR_W - LINE_BITS;

	logic [ADDR_W-1:0] scaled_index;
	logic [ADDR_W-1:0] ea;
	logic [LINE_W-1:0] line_num;

	// Index shifted by the access scale
	assign scaled_index = index << scale;

	// Mode select, an unused encoding falls back to base only
	always_comb begin
		case (mode)
			AM_DISP:    ea = base + disp;
			AM_INDEXED: ea = base + scaled_index + disp;
			default:    ea = base;
		endcase
	end

	// Following line number, the carry out of the top bit is dropped
	assign line_num = ea[ADDR_W-1:LINE_BITS] + LINE_W'(1);

	// Address register, loaded once per request
	always_ff @(posedge clk) begin
		if (issue) begin
			res <= next_line ? {line_num, {LINE_BITS{1'b0}}} : ea;
		end
	end

	// Result valid is sticky
	// It comes up one edge after issue and holds until the controller
	// releases it at the end of the request
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (res_release) begin
			res_valid <= 1'b0;
		end else if (issue) begin
			res_valid <= 1'b1;
		end
	end

endmodule

/* src/dtlb.sv */
/*
 * Small fully associative data TLB.
 * Entries are loaded through the write port and looked up over the
 * lookup interface. The result is registered, so hit and paddr appear
 * together with result_valid one cycle after the lookup pulse.
 */

`timescale 1ns/1ps

module dtlb import lsu_pkg::*; #(
	parameter int ADDR_W      = 32,
	parameter int TLB_ENTRIES = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        tlb_we,
	input  logic [idx_width(TLB_ENTRIES)-1:0] tlb_index,
	input  logic [ADDR_W-PAGE_BITS-1:0] tlb_vpn,
	input  logic [ADDR_W-PAGE_BITS-1:0] tlb_ppn,
	tlb_lookup_if.tlb                   lk
);

	// Page number width, virtual and physical are the same size
	localparam int VPN_W = ADDR_W - PAGE_BITS;

	// ==================================================
	// Entry storage
	// ==================================================

	logic [TLB_ENTRIES-1:0] valid;
	logic [VPN_W-1:0]       vpn_tab [TLB_ENTRIES];
	logic [VPN_W-1:0]       ppn_tab [TLB_ENTRIES];

	// Only the valid bits are cleared, stale tags are harmless
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (tlb_we) begin
			valid[tlb_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tlb_we) begin
			vpn_tab[tlb_index] <= tlb_vpn;
			ppn_tab[tlb_index] <= tlb_ppn;
		end
	end

	// ==================================================
	// Parallel compare
	// ==================================================

	logic             match;
	logic [VPN_W-1:0] match_ppn;

	// Scan from the top down so the lowest matching index is left standing
	always_comb begin
		match     = 1'b0;
		match_ppn = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (valid[i] && (vpn_tab[i] == lk.vaddr[ADDR_W-1:PAGE_BITS])) begin
				match     = 1'b1;
				match_ppn = ppn_tab[i];
			end
		end
	end

	// Result registers
	// The page offset passes through untranslated
	always_ff @(posedge clk) begin
		if (lk.lookup) begin
			lk.hit   <= match;
			lk.paddr <= {match_ppn, lk.vaddr[PAGE_BITS-1:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lk.result_valid <= 1'b0;
		end else begin
			lk.result_valid <= lk.lookup;
		end
	end

endmodule

/* src/lsu_ctrl.sv */
/*
 * Request sequencer and Wishbone classic master.
 * Accepts one request, starts the address generator, translates the
 * address through the TLB and runs one bus cycle on a hit. A miss ends
 * the request with fault and no bus cycle. done pulses at the end.
 */

`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  logic                clk,
	input  logic                rst,

	// Request port
	input  logic                req,
	input  logic                we,
	input  logic [DATA_W-1:0]   wdata,
	output logic                busy,
	output logic                done,
	output logic [DATA_W-1:0]   rdata,
	output logic                fault,

	// Address generator handshake
	output logic                issue,
	output logic                res_release,
	input  logic [ADDR_W-1:0]   res,
	input  logic                res_valid,

	// Translation
	tlb_lookup_if.ctrl          lk,

	// Wishbone classic master
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output logic [ADDR_W-1:0]   wb_adr,
	output logic [DATA_W/8-1:0] wb_sel,
	output logic [DATA_W-1:0]   wb_dat_o,
	input  logic [DATA_W-1:0]   wb_dat_i,
	input  logic                wb_ack
);

	lsu_state_e        state;
	logic              looked;
	logic              we_q;
	logic [DATA_W-1:0] wdata_q;

	// ==================================================
	// Decoded controls
	// ==================================================

	// Busy for the whole request, including the done cycle
	assign busy = (state != ST_IDLE);

	// AGEN lasts exactly one cycle, which makes issue a pulse
	assign issue = (state == ST_AGEN);

	// Only one lookup per request, looked blocks a second pulse while
	// waiting for the registered TLB result
	assign lk.lookup = (state == ST_XLATE) && res_valid && !looked;
	assign lk.vaddr  = res;

	// The final cycle both reports and frees the agen result
	assign done        = (state == ST_DONE);
	assign res_release = (state == ST_DONE);

	// Full-width accesses only
	assign wb_sel   = '1;
	assign wb_we    = we_q;
	assign wb_dat_o = wdata_q;

	// ==================================================
	// State machine
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_IDLE;
			looked <= 1'b0;
			fault  <= 1'b0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req) begin
						fault <= 1'b0;
						state <= ST_AGEN;
					end
				end
				ST_AGEN: begin
					looked <= 1'b0;
					state  <= ST_XLATE;
				end
				ST_XLATE: begin
					if (lk.lookup) begin
						looked <= 1'b1;
					end
					// Result arrives one cycle after the lookup pulse
					if (lk.result_valid) begin
						if (lk.hit) begin
							wb_cyc <= 1'b1;
							wb_stb <= 1'b1;
							state  <= ST_BUS;
						end else begin
							fault <= 1'b1;
							state <= ST_DONE;
						end
					end
				end
				ST_BUS: begin
					// Wait states simply hold everything in place
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						state  <= ST_DONE;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Payload registers
	// ==================================================

	always_ff @(posedge clk) begin
		// Direction and store data are taken at acceptance
		if ((state == ST_IDLE) && req) begin
			we_q    <= we;
			wdata_q <= wdata;
		end
		// Physical address is set up together with cyc and stb
		if ((state == ST_XLATE) && lk.result_valid) begin
			wb_adr <= lk.paddr;
		end
		// Load data is captured on the ack edge
		if ((state == ST_BUS) && wb_ack && !we_q) begin
			rdata <= wb_dat_i;
		end
	end

endmodule

/* src/mem_access_unit.sv */
/*
 * Top level of the load/store address path.
 * Joins the address generator, the data TLB and the controller.
 * A request is taken when req is high and busy is low. The operands
 * must stay steady while busy is high, done marks the end.
 */

`timescale 1ns/1ps

module mem_access_unit import lsu_pkg::*; #(
	parameter int ADDR_W      = 32,
	parameter int DATA_W      = 32,
	parameter int TLB_ENTRIES = 4
) (
	input  logic                        clk,
	input  logic                        rst,

	// Request port
	input  logic                        req,
	input  logic                        we,
	input  addr_mode_e                  mode,
	input  logic                        next_line,
	input  logic [ADDR_W-1:0]           base,
	input  logic [ADDR_W-1:0]           index,
	input  logic [ADDR_W-1:0]           disp,
	input  logic [SCALE_W-1:0]          scale,
	input  logic [DATA_W-1:0]           wdata,
	output logic                        busy,
	output logic                        done,
	output logic [DATA_W-1:0]           rdata,
	output logic                        fault,

	// TLB fill port
	input  logic                        tlb_we,
	input  logic [idx_width(TLB_ENTRIES)-1:0] tlb_index,
	input  logic [ADDR_W-PAGE_BITS-1:0] tlb_vpn,
	input  logic [ADDR_W-PAGE_BITS-1:0] tlb_ppn,

	// Wishbone classic master
	output logic                        wb_cyc,
	output logic                        wb_stb,
	output logic                        wb_we,
	output logic [ADDR_W-1:0]           wb_adr,
	output logic [DATA_W/8-1:0]         wb_sel,
	output logic [DATA_W-1:0]           wb_dat_o,
	input  logic [DATA_W-1:0]           wb_dat_i,
	input  logic                        wb_ack
);

	// Agen handshake
	logic              issue;
	logic              res_release;
	logic [ADDR_W-1:0] res;
	logic              res_valid;

	tlb_lookup_if #(.ADDR_W(ADDR_W)) lk ();

	agen #(.ADDR_W(ADDR_W)) u_agen (
		.clk(clk), .rst(rst), .issue(issue), .res_release(res_release),
		.mode(mode), .next_line(next_line), .base(base), .index(index),
		.disp(disp), .scale(scale), .res(res), .res_valid(res_valid)
	);

	dtlb #(.ADDR_W(ADDR_W), .TLB_ENTRIES(TLB_ENTRIES)) u_dtlb (
		.clk(clk), .rst(rst), .tlb_we(tlb_we), .tlb_index(tlb_index),
		.tlb_vpn(tlb_vpn), .tlb_ppn(tlb_ppn), .lk(lk.tlb)
	);

	lsu_ctrl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_lsu_ctrl (
		.clk(clk), .rst(rst), .req(req), .we(we), .wdata(wdata),
		.busy(busy), .done(done), .rdata(rdata), .fault(fault),
		.issue(issue), .res_release(res_release), .res(res),
		.res_valid(res_valid), .lk(lk.ctrl),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_sel(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

endmodule

/* verification/mem_access_unit_asserts.sv */
/*
 * Concurrent checks on the bus and the request handshake.
 * The testbench binds this module into the controller, so it sees the
 * Wishbone outputs, the request flags and the state register directly.
 */

`timescale 1ns/1ps

module mem_access_unit_asserts import lsu_pkg::*; #(
	parameter int ADDR_W = 32
) (
	input logic              clk,
	input logic              rst,
	input logic              busy,
	input logic              done,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_we,
	input logic              wb_ack,
	input logic [ADDR_W-1:0] wb_adr,
	input lsu_state_e        state
);

	// A strobe is only legal inside a bus cycle
	stb_in_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_stb |-> wb_cyc)
		else $error("wb_stb high while wb_cyc is low");

	// Address and direction hold through every wait state
	adr_we_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we)))
		else $error("wb_adr or wb_we changed before the ack");

	// done never lasts more than one cycle
	done_single: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// Every reset edge leaves the controller idle
	idle_after_reset: assert property (@(posedge clk)
		rst |=> (!busy && (state == ST_IDLE)))
		else $error("busy or state not idle after reset");

endmodule

/* verification/tb_mem_access_unit.sv */
/*
 * Directed testbench for the memory access unit.
 * Drives requests and TLB fills on the falling edge and models a word
 * memory that answers Wishbone with 0 to 3 wait states. Every request
 * is compared with an address and TLB model built from the access rules.
 * Run it with the Makefile in the project root.
 */

`timescale 1ns/1ps

module tb_mem_access_unit import lsu_pkg::*; ();

	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int VPN_W   = ADDR_W - PAGE_BITS;
	localparam int TIMEOUT = 100;

	logic                clk;
	logic                rst;
	logic                req;
	logic                we;
	addr_mode_e          mode;
	logic                next_line;
	logic [ADDR_W-1:0]   base;
	logic [ADDR_W-1:0]   index;
	logic [ADDR_W-1:0]   disp;
	logic [SCALE_W-1:0]  scale;
	logic [DATA_W-1:0]   wdata;
	logic                busy;
	logic                done;
	logic [DATA_W-1:0]   rdata;
	logic                fault;
	logic                tlb_we;
	logic [1:0]          tlb_index;
	logic [VPN_W-1:0]    tlb_vpn;
	logic [VPN_W-1:0]    tlb_ppn;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [ADDR_W-1:0]   wb_adr;
	logic [DATA_W/8-1:0] wb_sel;
	logic [DATA_W-1:0]   wb_dat_o;
	logic [DATA_W-1:0]   wb_dat_i;
	logic                wb_ack;

	integer seed;

	// Mirror of the TLB contents that is written together with each fill
	logic [3:0]        map_valid;
	logic [VPN_W-1:0]  map_vpn [4];
	logic [VPN_W-1:0]  map_ppn [4];

	// Memory model state and the record of the last completed transfer
	logic [DATA_W-1:0] mem [logic [ADDR_W-3:0]];
	logic              in_cycle;
	int                wait_left;
	int                next_waits;
	int                waits_total;
	int                cyc_count;
	logic [ADDR_W-1:0] bus_adr;
	logic              bus_we;
	logic [DATA_W/8-1:0] bus_sel;
	logic [DATA_W-1:0] bus_dat;

	// Outcome of the last request
	logic              got_fault;
	logic [DATA_W-1:0] got_rdata;
	logic              got_bus;

	mem_access_unit u_mem_access_unit (.*);

	bind lsu_ctrl mem_access_unit_asserts #(.ADDR_W(ADDR_W)) u_asserts (
		.clk(clk), .rst(rst), .busy(busy), .done(done), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_we(wb_we), .wb_ack(wb_ack), .wb_adr(wb_adr),
		.state(state)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================
	// Wishbone memory model
	// ==================================================

	// Unwritten words read back a value tied to the full address
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] adr);
		return adr ^ 32'hc3a5_0f96;
	endfunction

	initial begin
		wb_ack    = 1'b0;
		wb_dat_i  = '0;
		in_cycle  = 1'b0;
		wait_left = 0;
		cyc_count = 0;
		bus_adr   = '0;
		bus_we    = 1'b0;
		bus_sel   = '0;
		bus_dat   = '0;
		forever begin
			@(negedge clk);
			if (wb_cyc) begin
				cyc_count = cyc_count + 1;
			end
			if (wb_ack) begin
				// The master has seen the ack so the cycle is over
				wb_ack   = 1'b0;
				in_cycle = 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (!in_cycle) begin
					in_cycle  = 1'b1;
					wait_left = next_waits;
				end
				if (wait_left == 0) begin
					bus_adr = wb_adr;
					bus_we  = wb_we;
					bus_sel = wb_sel;
					bus_dat = wb_dat_o;
					if (wb_we) begin
						mem[wb_adr[ADDR_W-1:2]] = wb_dat_o;
					end else if (mem.exists(wb_adr[ADDR_W-1:2])) begin
						wb_dat_i = mem[wb_adr[ADDR_W-1:2]];
					end else begin
						wb_dat_i = fill_word(wb_adr);
					end
					wb_ack = 1'b1;
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	// ==================================================
	// Reference model and helpers
	// ==================================================

	// Virtual address from the mode rules followed by the next-line rounding
	function automatic logic [ADDR_W-1:0] effective_addr(input addr_mode_e m,
		input logic nl, input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] ix,
		input logic [ADDR_W-1:0] d, input logic [SCALE_W-1:0] sc);
		logic [ADDR_W-1:0] ea;
		if (m == AM_INDEXED) begin
			ea = b + ix * (ADDR_W'(1) << sc) + d;
		end else if (m == AM_DISP) begin
			ea = b + d;
		end else begin
			ea = b;
		end
		if (nl) begin
			ea = (ea & ~ADDR_W'(63)) + ADDR_W'(64);
		end
		return ea;
	endfunction

	// The first valid entry with the page wins and unmapped pages pass through
	function automatic logic [ADDR_W-1:0] translate(input logic [ADDR_W-1:0] va);
		for (int i = 0; i < 4; i++) begin
			if (map_valid[i] && (map_vpn[i] == va[ADDR_W-1:PAGE_BITS])) begin
				return {map_ppn[i], va[PAGE_BITS-1:0]};
			end
		end
		return va;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail %s got %h expected %h", name, got, expected);
			$display("Finished with errors");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic tlb_write(input logic [1:0] idx, input logic [VPN_W-1:0] vpn,
		input logic [VPN_W-1:0] ppn);
		@(negedge clk);
		tlb_we    = 1'b1;
		tlb_index = idx;
		tlb_vpn   = vpn;
		tlb_ppn   = ppn;
		@(negedge clk);
		tlb_we         = 1'b0;
		map_valid[idx] = 1'b1;
		map_vpn[idx]   = vpn;
		map_ppn[idx]   = ppn;
	endtask

	// Runs one request from acceptance to done and expects busy high throughout
	task automatic run_access(input logic st, input addr_mode_e m, input logic nl,
		input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] ix,
		input logic [ADDR_W-1:0] d, input logic [SCALE_W-1:0] sc,
		input logic [DATA_W-1:0] wd);
		int cycles;
		int cyc_before;
		cycles = 0;
		@(negedge clk);
		req         = 1'b1;
		we          = st;
		mode        = m;
		next_line   = nl;
		base        = b;
		index       = ix;
		disp        = d;
		scale       = sc;
		wdata       = wd;
		next_waits  = $random(seed) & 3;
		waits_total = waits_total + next_waits;
		cyc_before  = cyc_count;
		@(negedge clk);
		req = 1'b0;
		while (!done) begin
			check_value("busy", 32'(busy), 32'd1);
			if (cycles == TIMEOUT) begin
				$display("Timeout: done did not come for the request");
				$display("Finished with errors");
				$fatal(1, "Request timed out");
			end
			cycles = cycles + 1;
			@(negedge clk);
		end
		check_value("busy", 32'(busy), 32'd1);
		got_fault = fault;
		got_rdata = rdata;
		got_bus   = (cyc_count != cyc_before);
	endtask

	// Load through a mapped page and compare the physical bus address
	task automatic expect_bus_address(input addr_mode_e m, input logic nl,
		input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] ix,
		input logic [ADDR_W-1:0] d, input logic [SCALE_W-1:0] sc);
		run_access(1'b0, m, nl, b, ix, d, sc, '0);
		check_value("fault", 32'(got_fault), 32'd0);
		check_value("wb_cyc seen", 32'(got_bus), 32'd1);
		check_value("wb_we", 32'(bus_we), 32'd0);
		check_value("wb_sel", 32'(bus_sel), 32'h0000_000f);
		check_value("wb_adr", bus_adr, translate(effective_addr(m, nl, b, ix, d, sc)));
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic addressing_modes();
		tlb_write(2'd0, 20'h00010, 20'h00345);
		// Index and displacement are ignored in base-only mode
		expect_bus_address(AM_BASE, 1'b0, 32'h0001_0120, 32'h100, 32'h40, 2'd1);
		expect_bus_address(AM_DISP, 1'b0, 32'h0001_0100, 32'h0, 32'h24, 2'd0);
		expect_bus_address(AM_DISP, 1'b0, 32'h0001_0800, 32'h0, 32'hffff_fff0, 2'd0);
		for (int s = 0; s < 4; s++) begin
			expect_bus_address(AM_INDEXED, 1'b0, 32'h0001_0040, 32'h10, 32'h8,
				SCALE_W'(s));
		end
	endtask

	task automatic next_line_rounding();
		// Unaligned 0x123 rounds up to 0x140 and aligned 0x140 moves to 0x180
		expect_bus_address(AM_DISP, 1'b1, 32'h0001_0100, 32'h0, 32'h23, 2'd0);
		check_value("wb_adr", bus_adr, 32'h0034_5140);
		expect_bus_address(AM_BASE, 1'b1, 32'h0001_0140, 32'h0, 32'h0, 2'd0);
		check_value("wb_adr", bus_adr, 32'h0034_5180);
	endtask

	task automatic store_then_load();
		logic [ADDR_W-1:0] va;
		logic [DATA_W-1:0] data;
		tlb_write(2'd1, 20'h00020, 20'h00777);
		for (int i = 0; i < 8; i++) begin
			va   = {(($random(seed) & 1) != 0) ? 20'h00010 : 20'h00020, 12'h000};
			va   = va | ($random(seed) & 32'h0000_0ffc);
			data = $random(seed);
			run_access(1'b1, AM_BASE, 1'b0, va, '0, '0, '0, data);
			check_value("fault", 32'(got_fault), 32'd0);
			check_value("wb_we", 32'(bus_we), 32'd1);
			check_value("wb_sel", 32'(bus_sel), 32'h0000_000f);
			check_value("wb_adr", bus_adr, translate(va));
			check_value("wb_dat_o", bus_dat, data);
			run_access(1'b0, AM_BASE, 1'b0, va, '0, '0, '0, '0);
			check_value("fault", 32'(got_fault), 32'd0);
			check_value("wb_we", 32'(bus_we), 32'd0);
			check_value("rdata", got_rdata, data);
		end
	endtask

	task automatic miss_faults();
		// Page never mapped at all
		run_access(1'b0, AM_BASE, 1'b0, 32'h0009_9010, '0, '0, '0, '0);
		check_value("fault", 32'(got_fault), 32'd1);
		check_value("wb_cyc seen", 32'(got_bus), 32'd0);
		// Page 0 is in no written entry and entries 2 and 3 were never written
		run_access(1'b1, AM_DISP, 1'b0, 32'h0000_0000, '0, 32'h10, '0, 32'h1234_5678);
		check_value("fault", 32'(got_fault), 32'd1);
		check_value("wb_cyc seen", 32'(got_bus), 32'd0);
	endtask

	task automatic remapped_page();
		tlb_write(2'd0, 20'h00010, 20'h00abc);
		expect_bus_address(AM_DISP, 1'b0, 32'h0001_0200, 32'h0, 32'h14, 2'd0);
		check_value("wb_adr page", bus_adr >> PAGE_BITS, 32'h0000_0abc);
	endtask

	task automatic back_pressure();
		logic [ADDR_W-1:0] va;
		logic [DATA_W-1:0] data;
		int waits_before;
		waits_before = waits_total;
		for (int i = 0; i < 6; i++) begin
			va   = 32'h0002_0000 | ($random(seed) & 32'h0000_0ffc);
			data = $random(seed);
			run_access(1'b1, AM_BASE, 1'b0, va, '0, '0, '0, data);
			check_value("fault", 32'(got_fault), 32'd0);
			run_access(1'b0, AM_BASE, 1'b0, va, '0, '0, '0, '0);
			check_value("fault", 32'(got_fault), 32'd0);
			check_value("rdata", got_rdata, data);
		end
		check_value("wait states used", 32'(waits_total != waits_before), 32'd1);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		seed        = 32'ha647;
		req         = 1'b0;
		we          = 1'b0;
		mode        = AM_BASE;
		next_line   = 1'b0;
		base        = '0;
		index       = '0;
		disp        = '0;
		scale       = '0;
		wdata       = '0;
		tlb_we      = 1'b0;
		tlb_index   = '0;
		tlb_vpn     = '0;
		tlb_ppn     = '0;
		map_valid   = '0;
		next_waits  = 0;
		waits_total = 0;
		got_fault   = 1'b0;
		got_rdata   = '0;
		got_bus     = 1'b0;
		rst         = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		check_value("busy", 32'(busy), 32'd0);
		check_value("done", 32'(done), 32'd0);
		addressing_modes();
		next_line_rounding();
		store_then_load();
		miss_faults();
		remapped_page();
		back_pressure();
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* sources.f */
src/lsu_pkg.sv
src/tlb_lookup_if.sv
src/agen.sv
src/dtlb.sv
src/lsu_ctrl.sv
src/mem_access_unit.sv
verification/mem_access_unit_asserts.sv
verification/tb_mem_access_unit.sv

/* Makefile */
# Verilator build and run of the memory access unit testbench
# The exit status of the simulation is the test result

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_mem_access_unit \
		-f sources.f -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
